// ==== source/decodePkg.sv ====
package decodePkg;

    localparam int xLen = 32;
    localparam int regAddrWidth = 5;

    // funct3 codes shared by the ALU groups
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Sr = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt = 7'b0100000;

    typedef enum logic [6:0] {
        rType = 7'b0110011,
        iType = 7'b0010011,
        load = 7'b0000011,
        store = 7'b0100011,
        branch = 7'b1100011,
        jal = 7'b1101111,
        jalr = 7'b1100111,
        lui = 7'b0110111,
        auipc = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr = 4'd3,
        aluXor = 4'd4,
        aluSll = 4'd5,
        aluSrl = 4'd6,
        aluSra = 4'd7,
        aluSlt = 4'd8,
        aluSltu = 4'd9,
        aluBeq = 4'd10,
        aluBne = 4'd11,
        aluBlt = 4'd12,
        aluBge = 4'd13,
        aluBltu = 4'd14,
        aluBgeu = 4'd15
    } aluOpT;

    typedef enum logic [1:0] {
        memDisable = 2'b00,
        memReadSext = 2'b01,
        memReadZext = 2'b10,
        memWrite = 2'b11
    } memOpT;

    // Code 2'b11 is left unused
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } memSizeT;

    typedef enum logic {
        selRs1 = 1'b0,
        selPc = 1'b1
    } selAT;

    typedef enum logic [1:0] {
        selRs2 = 2'b00,
        selImm = 2'b01,
        selFour = 2'b10
    } selBT;

    typedef struct packed {
        aluOpT aluOp;
        selAT selA;
        selBT selB;
        logic aluToReg;
        memOpT memOp;
        memSizeT memSize;
        logic branch;
        logic jal;
        logic jalr;
    } ctrlT;

    typedef struct packed {
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
        logic [xLen-1:0] imm;
        ctrlT ctrl;
    } decodedT;

    localparam ctrlT ctrlIdle = '{
        aluOp: aluAdd,
        selA: selRs1,
        selB: selRs2,
        aluToReg: 1'b0,
        memOp: memDisable,
        memSize: sizeByte,
        branch: 1'b0,
        jal: 1'b0,
        jalr: 1'b0
    };

endpackage

// ==== source/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  logic [decodePkg::xLen-1:0] instruction,
    output logic [decodePkg::xLen-1:0] imm
);
    import decodePkg::*;

    opcodeT opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [xLen-1:0] immI;
    logic [xLen-1:0] immS;
    logic [xLen-1:0] immB;
    logic [xLen-1:0] immU;
    logic [xLen-1:0] immJ;
    logic [xLen-1:0] immShamt;
    logic shiftOk;

    assign opcode = opcodeT'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};
    assign immShamt = {{(xLen-5){1'b0}}, instruction[24:20]};

    // SRAI is the only shift allowed to set funct7 bit 5
    assign shiftOk = (funct7 == f7Base) || (funct3 == f3Sr && funct7 == f7Alt);

    always_comb begin
        imm = '0;
        case (opcode)
            iType: begin
                if (funct3 == f3Sll || funct3 == f3Sr) begin
                    imm = shiftOk ? immShamt : '0;
                end else begin
                    imm = immI;
                end
            end
            load: imm = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ? immI : '0;
            store: imm = (funct3 <= 3'b010) ? immS : '0;
            branch: imm = (funct3 inside {3'b010, 3'b011}) ? '0 : immB;
            jal: imm = immJ;
            jalr: imm = (funct3 == 3'b000) ? immI : '0;
            lui, auipc: imm = immU;
            default: imm = '0;
        endcase
    end

endmodule

// ==== source/controlDecode.sv ====
`timescale 1ns/1ps

module controlDecode (
    input  logic [decodePkg::xLen-1:0] instruction,
    output decodePkg::ctrlT ctrl,
    output logic isLoad,
    output logic writesReg
);
    import decodePkg::*;

    opcodeT opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeT'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // Base ALU op for funct3, ignoring the funct7 variants
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3);
        case (f3)
            f3AddSub: return aluAdd;
            f3Sll: return aluSll;
            f3Slt: return aluSlt;
            f3Sltu: return aluSltu;
            f3Xor: return aluXor;
            f3Sr: return aluSrl;
            f3Or: return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_comb begin
        ctrl = ctrlIdle;
        case (opcode)
            rType: begin
                if (funct7 == f7Base) begin
                    ctrl.aluOp = aluFromFunct3(funct3);
                    ctrl.aluToReg = 1'b1;
                end else if (funct7 == f7Alt && (funct3 == f3AddSub || funct3 == f3Sr)) begin
                    ctrl.aluOp = (funct3 == f3AddSub) ? aluSub : aluSra;
                    ctrl.aluToReg = 1'b1;
                end
            end
            iType: begin
                if ((funct3 != f3Sll && funct3 != f3Sr) || funct7 == f7Base) begin
                    ctrl.aluOp = aluFromFunct3(funct3);
                    ctrl.selB = selImm;
                    ctrl.aluToReg = 1'b1;
                end else if (funct3 == f3Sr && funct7 == f7Alt) begin
                    ctrl.aluOp = aluSra;
                    ctrl.selB = selImm;
                    ctrl.aluToReg = 1'b1;
                end
            end
            load: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    // funct3[2] marks the unsigned loads
                    ctrl.selB = selImm;
                    ctrl.memOp = funct3[2] ? memReadZext : memReadSext;
                    ctrl.memSize = memSizeT'(funct3[1:0]);
                end
            end
            store: begin
                if (funct3 <= 3'b010) begin
                    ctrl.selB = selImm;
                    ctrl.memOp = memWrite;
                    ctrl.memSize = memSizeT'(funct3[1:0]);
                end
            end
            branch: begin
                if (!(funct3 inside {3'b010, 3'b011})) begin
                    ctrl.branch = 1'b1;
                    case (funct3)
                        3'b000: ctrl.aluOp = aluBeq;
                        3'b001: ctrl.aluOp = aluBne;
                        3'b100: ctrl.aluOp = aluBlt;
                        3'b101: ctrl.aluOp = aluBge;
                        3'b110: ctrl.aluOp = aluBltu;
                        default: ctrl.aluOp = aluBgeu;
                    endcase
                end
            end
            jal: begin
                ctrl.selA = selPc;
                ctrl.selB = selFour;
                ctrl.aluToReg = 1'b1;
                ctrl.jal = 1'b1;
            end
            jalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.selA = selPc;
                    ctrl.selB = selFour;
                    ctrl.aluToReg = 1'b1;
                    ctrl.jalr = 1'b1;
                end
            end
            lui: begin
                ctrl.selB = selImm;
                ctrl.aluToReg = 1'b1;
            end
            auipc: begin
                ctrl.selA = selPc;
                ctrl.selB = selImm;
                ctrl.aluToReg = 1'b1;
            end
            default: ctrl = ctrlIdle;
        endcase
    end

    assign isLoad = (opcode == load);
    // Collision class goes by opcode alone
    assign writesReg = opcode inside {rType, iType, jal, jalr, lui, auipc};

endmodule

// ==== source/decodeRegister.sv ====
`timescale 1ns/1ps

module decodeRegister (
    input  logic clk,
    input  logic rstN,
    input  logic hold,
    input  logic [decodePkg::xLen-1:0] instruction,
    input  logic [decodePkg::xLen-1:0] imm,
    input  decodePkg::ctrlT ctrl,
    input  logic isLoad,
    input  logic writesReg,
    output decodePkg::decodedT decoded,
    output logic regWriteCollision
);
    import decodePkg::*;

    logic prevLoad;
    logic [regAddrWidth-1:0] rs1Field;

    // LUI reads x0 so the ALU adds zero to the immediate
    assign rs1Field = (opcodeT'(instruction[6:0]) == lui) ? '0 : instruction[19:15];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decoded <= '{rs1: '0, rs2: '0, rd: '0, imm: '0, ctrl: ctrlIdle};
            prevLoad <= 1'b0;
            regWriteCollision <= 1'b0;
        end else begin
            // Load tracking ignores hold
            prevLoad <= isLoad;
            regWriteCollision <= prevLoad && writesReg;
            if (!hold) begin
                decoded <= '{
                    rs1: rs1Field,
                    rs2: instruction[24:20],
                    rd: instruction[11:7],
                    imm: imm,
                    ctrl: ctrl
                };
            end
        end
    end

    memSizeLegal: assert property (@(posedge clk) disable iff (!rstN)
        decoded.ctrl.memOp != memDisable |-> decoded.ctrl.memSize != memSizeT'(2'b11));

    holdKeepsDecoded: assert property (@(posedge clk)
        rstN && hold |=> $stable(decoded));

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  logic [decodePkg::xLen-1:0] instruction,
    input  logic hold,
    output decodePkg::decodedT decoded,
    output logic regWriteCollision
);
    import decodePkg::*;

    logic [xLen-1:0] imm;
    ctrlT ctrl;
    logic isLoad;
    logic writesReg;

    immGen uImmGen (
        .instruction(instruction),
        .imm(imm)
    );

    controlDecode uControlDecode (
        .instruction(instruction),
        .ctrl(ctrl),
        .isLoad(isLoad),
        .writesReg(writesReg)
    );

    decodeRegister uDecodeRegister (
        .clk(clk),
        .rstN(rstN),
        .hold(hold),
        .instruction(instruction),
        .imm(imm),
        .ctrl(ctrl),
        .isLoad(isLoad),
        .writesReg(writesReg),
        .decoded(decoded),
        .regWriteCollision(regWriteCollision)
    );

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);
    localparam int halfPeriod = 20;
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Release lands on a rising edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// ==== verif/decodeStageTb.sv ====
`timescale 1ns/1ps

module decodeStageTb;
    import decodePkg::*;

    localparam int clkPeriod = 40;
    localparam int cycleMargin = 12;
    localparam int resetCycles = 4;

    typedef struct packed {
        logic [xLen-1:0] instr;
        logic hold;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
        logic [xLen-1:0] imm;
        ctrlT ctrl;
        logic coll;
    } rowT;

    logic clk;
    logic rstN;
    logic [xLen-1:0] instruction;
    logic hold;
    decodedT decoded;
    logic regWriteCollision;

    rowT rows[$];
    integer seed = 32'h2281a4d8;
    int errorCount = 0;
    int checkCount = 0;
    int rowIdx = -1;
    logic tableReady = 1'b0;

    tbClock uClock (
        .clk(clk),
        .rstN(rstN)
    );

    decodeStage uut (
        .clk(clk),
        .rstN(rstN),
        .instruction(instruction),
        .hold(hold),
        .decoded(decoded),
        .regWriteCollision(regWriteCollision)
    );

    function automatic logic [4:0] randReg();
        integer v;
        v = $random(seed);
        return v[4:0];
    endfunction

    // Instruction encoders with random register numbers
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, randReg(), randReg(), f3, randReg(), rType};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] v, input logic [2:0] f3,
                                         input logic [6:0] op);
        return {v, randReg(), f3, randReg(), op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] v, input logic [2:0] f3);
        return {v[11:5], randReg(), randReg(), f3, v[4:0], store};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] v, input logic [2:0] f3);
        return {v[12], v[10:5], randReg(), randReg(), f3, v[4:1], v[11], branch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] v, input logic [6:0] op);
        return {v, randReg(), op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] v);
        return {v[20], v[10:1], v[11], v[19:12], randReg(), jal};
    endfunction

    function automatic ctrlT makeCtrl(input aluOpT a, input selAT sa, input selBT sb,
                                      input logic w, input memOpT mo, input memSizeT ms,
                                      input logic br, input logic j, input logic jr);
        return '{aluOp: a, selA: sa, selB: sb, aluToReg: w, memOp: mo, memSize: ms,
                 branch: br, jal: j, jalr: jr};
    endfunction

    function automatic ctrlT aluCtrl(input aluOpT a, input selBT sb);
        return makeCtrl(a, selRs1, sb, 1'b1, memDisable, sizeByte, 1'b0, 1'b0, 1'b0);
    endfunction

    function automatic ctrlT memCtrl(input memOpT mo, input memSizeT ms);
        return makeCtrl(aluAdd, selRs1, selImm, 1'b0, mo, ms, 1'b0, 1'b0, 1'b0);
    endfunction

    function automatic ctrlT brCtrl(input aluOpT a);
        return makeCtrl(a, selRs1, selRs2, 1'b0, memDisable, sizeByte, 1'b1, 1'b0, 1'b0);
    endfunction

    function automatic ctrlT idleCtrl();
        return makeCtrl(aluAdd, selRs1, selRs2, 1'b0, memDisable, sizeByte, 1'b0, 1'b0, 1'b0);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR at %0t ns: row %0d %s is %h, expected %h",
                     $time, rowIdx, name, actual, expected);
        end
    endtask

    task automatic checkRow(input rowT r);
        checkValue("rs1", 32'(decoded.rs1), 32'(r.rs1));
        checkValue("rs2", 32'(decoded.rs2), 32'(r.rs2));
        checkValue("rd", 32'(decoded.rd), 32'(r.rd));
        checkValue("imm", decoded.imm, r.imm);
        checkValue("ctrl", 32'(decoded.ctrl), 32'(r.ctrl));
        checkValue("regWriteCollision", 32'(regWriteCollision), 32'(r.coll));
    endtask

    // Register fields come straight from the word and LUI reads x0
    task automatic addRow(input logic [31:0] instr, input logic [31:0] imm,
                          input ctrlT ctrl, input logic coll);
        rowT r;
        r.instr = instr;
        r.hold = 1'b0;
        r.rs1 = (instr[6:0] == 7'b0110111) ? 5'd0 : instr[19:15];
        r.rs2 = instr[24:20];
        r.rd = instr[11:7];
        r.imm = imm;
        r.ctrl = ctrl;
        r.coll = coll;
        rows.push_back(r);
    endtask

    // Held row expects the previous decode to stay
    task automatic addHeld(input logic [31:0] instr, input logic coll);
        rowT r;
        r = rows[$];
        r.instr = instr;
        r.hold = 1'b1;
        r.coll = coll;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        addRow(encR(7'h00, 3'd0), 32'h0, aluCtrl(aluAdd, selRs2), 1'b0);
        addRow(encR(7'h20, 3'd0), 32'h0, aluCtrl(aluSub, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd1), 32'h0, aluCtrl(aluSll, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd2), 32'h0, aluCtrl(aluSlt, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd3), 32'h0, aluCtrl(aluSltu, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd4), 32'h0, aluCtrl(aluXor, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd5), 32'h0, aluCtrl(aluSrl, selRs2), 1'b0);
        addRow(encR(7'h20, 3'd5), 32'h0, aluCtrl(aluSra, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd6), 32'h0, aluCtrl(aluOr, selRs2), 1'b0);
        addRow(encR(7'h00, 3'd7), 32'h0, aluCtrl(aluAnd, selRs2), 1'b0);
        addRow(encI(12'hFFB, 3'd0, iType), 32'hFFFFFFFB, aluCtrl(aluAdd, selImm), 1'b0);
        addRow(encI(12'h7FF, 3'd2, iType), 32'h000007FF, aluCtrl(aluSlt, selImm), 1'b0);
        addRow(encI(12'h800, 3'd3, iType), 32'hFFFFF800, aluCtrl(aluSltu, selImm), 1'b0);
        addRow(encI(12'h0F0, 3'd4, iType), 32'h000000F0, aluCtrl(aluXor, selImm), 1'b0);
        addRow(encI(12'hA55, 3'd6, iType), 32'hFFFFFA55, aluCtrl(aluOr, selImm), 1'b0);
        addRow(encI(12'h3C3, 3'd7, iType), 32'h000003C3, aluCtrl(aluAnd, selImm), 1'b0);
        addRow(encI(12'h007, 3'd1, iType), 32'h00000007, aluCtrl(aluSll, selImm), 1'b0);
        addRow(encI(12'h01F, 3'd5, iType), 32'h0000001F, aluCtrl(aluSrl, selImm), 1'b0);
        // SRAI keeps only the shamt
        addRow(encI(12'h40C, 3'd5, iType), 32'h0000000C, aluCtrl(aluSra, selImm), 1'b0);
        addRow(encI(12'h004, 3'd0, load), 32'h00000004, memCtrl(memReadSext, sizeByte), 1'b0);
        addRow(encI(12'hFFE, 3'd1, load), 32'hFFFFFFFE, memCtrl(memReadSext, sizeHalf), 1'b0);
        addRow(encI(12'h7F0, 3'd2, load), 32'h000007F0, memCtrl(memReadSext, sizeWord), 1'b0);
        addRow(encI(12'h800, 3'd4, load), 32'hFFFFF800, memCtrl(memReadZext, sizeByte), 1'b0);
        addRow(encI(12'h002, 3'd5, load), 32'h00000002, memCtrl(memReadZext, sizeHalf), 1'b0);
        // Store after a load writes no register
        addRow(encS(12'hFF8, 3'd0), 32'hFFFFFFF8, memCtrl(memWrite, sizeByte), 1'b0);
        addRow(encS(12'h024, 3'd1), 32'h00000024, memCtrl(memWrite, sizeHalf), 1'b0);
        addRow(encS(12'h800, 3'd2), 32'hFFFFF800, memCtrl(memWrite, sizeWord), 1'b0);
        addRow(encI(12'h010, 3'd2, load), 32'h00000010, memCtrl(memReadSext, sizeWord), 1'b0);
        addRow(encI(12'h001, 3'd0, iType), 32'h00000001, aluCtrl(aluAdd, selImm), 1'b1);
        addRow(encB(13'h0010, 3'd0), 32'h00000010, brCtrl(aluBeq), 1'b0);
        addRow(encB(13'h1FF0, 3'd1), 32'hFFFFFFF0, brCtrl(aluBne), 1'b0);
        addRow(encB(13'h0FFE, 3'd4), 32'h00000FFE, brCtrl(aluBlt), 1'b0);
        addRow(encB(13'h1000, 3'd5), 32'hFFFFF000, brCtrl(aluBge), 1'b0);
        addRow(encB(13'h0800, 3'd6), 32'h00000800, brCtrl(aluBltu), 1'b0);
        addRow(encB(13'h0002, 3'd7), 32'h00000002, brCtrl(aluBgeu), 1'b0);
        addRow(encJ(21'h100802), 32'hFFF00802, makeCtrl(aluAdd, selPc, selFour, 1'b1,
               memDisable, sizeByte, 1'b0, 1'b1, 1'b0), 1'b0);
        addRow(encI(12'hF01, 3'd0, jalr), 32'hFFFFFF01, makeCtrl(aluAdd, selPc, selFour, 1'b1,
               memDisable, sizeByte, 1'b0, 1'b0, 1'b1), 1'b0);
        addRow(encU(20'hDEADB, lui), 32'hDEADB000, aluCtrl(aluAdd, selImm), 1'b0);
        addRow(encU(20'h00001, auipc), 32'h00001000, makeCtrl(aluAdd, selPc, selImm, 1'b1,
               memDisable, sizeByte, 1'b0, 1'b0, 1'b0), 1'b0);
        addHeld(encR(7'h00, 3'd0), 1'b0);
        addHeld(encI(12'h055, 3'd4, iType), 1'b0);
        addRow(encI(12'h123, 3'd0, 7'h7F), 32'h0, idleCtrl(), 1'b0);
    endtask

    initial begin
        rowT resetRow;
        logic [31:0] resetAddi;
        instruction = encI(12'h044, 3'd2, load);
        hold = 1'b0;
        resetAddi = encI(12'h7AB, 3'd0, iType);
        buildTable();
        tableReady = 1'b1;
        resetRow = '0;
        resetRow.ctrl = idleCtrl();
        // Load then ADDI on the last reset edges, so only reset keeps decode and flag clear
        repeat (resetCycles - 1) @(posedge clk);
        instruction <= resetAddi;
        wait (rstN === 1'b1);
        @(negedge clk);
        checkRow(resetRow);
        // Row i goes in while row i-1 is on the output
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            instruction <= rows[i].instr;
            hold <= rows[i].hold;
            @(negedge clk);
            if (i > 0) begin
                rowIdx = i - 1;
                checkRow(rows[i - 1]);
            end
        end
        @(posedge clk);
        @(negedge clk);
        rowIdx = rows.size() - 1;
        checkRow(rows[$]);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (tableReady);
        #((rows.size() + cycleMargin) * clkPeriod);
        $display("Timeout: the decode table did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== project.f ====
source/decodePkg.sv
source/immGen.sv
source/controlDecode.sv
source/decodeRegister.sv
source/decodeStage.sv
verif/tbClock.sv
verif/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator

verilator --binary --assert --top-module decodeStageTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VdecodeStageTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
